// ==== hdl/uart_ctrl_if.sv ====
// control bundle between the register block and the transmit and receive paths
`timescale 1ns/10ps

interface uart_ctrl_if;
    import uart_pkg::*;

    // baud setting
    logic [DIVIDER_BITS-1:0] divider;

    // transmit byte stream
    logic [7:0] tx_data;
    logic tx_valid;
    logic tx_ready;
    logic [FIFO_PTR_BITS:0] tx_free_count;

    // receive byte stream
    logic [7:0] rx_data;
    logic rx_valid;
    logic rx_ready;
    logic [FIFO_PTR_BITS:0] rx_data_count;

    modport regs (
        output divider, tx_data, tx_valid, rx_ready,
        input tx_ready, tx_free_count, rx_data, rx_valid, rx_data_count
    );

    modport tx (
        input divider, tx_data, tx_valid,
        output tx_ready, tx_free_count
    );

    modport rx (
        input divider, rx_ready,
        output rx_data, rx_valid, rx_data_count
    );

endinterface

// ==== hdl/uart_fifo.sv ====
// synchronous byte FIFO with valid/ready on both ends and an occupancy count
`timescale 1ns/10ps

module uart_fifo (
    input  logic                             s_axi4l,
    input  logic                             rst_n,
    input  logic [7:0]                       in_data,
    input  logic                             in_valid,
    output logic                             in_ready,
    output logic [7:0]                       out_data,
    output logic                             out_valid,
    input  logic                             out_ready,
    output logic [uart_pkg::FIFO_PTR_BITS:0] count
);
    import uart_pkg::*;

    logic [7:0] mem [FIFO_DEPTH];
    logic [FIFO_PTR_BITS:0] wr_ptr;
    logic [FIFO_PTR_BITS:0] rd_ptr;
    logic push;
    logic pop;

    // pointers carry one extra wrap bit
    assign count     = wr_ptr - rd_ptr;
    assign in_ready  = (count != (FIFO_PTR_BITS+1)'(FIFO_DEPTH));
    assign out_valid = (count != '0);
    assign out_data  = mem[rd_ptr[FIFO_PTR_BITS-1:0]];

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    always_ff @(posedge s_axi4l) begin
        if (push) begin
            mem[wr_ptr[FIFO_PTR_BITS-1:0]] <= in_data;
        end
    end

    always_ff @(posedge s_axi4l) begin
        if (!rst_n) begin
            wr_ptr <= '0;
        end else if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    always_ff @(posedge s_axi4l) begin
        if (!rst_n) begin
            rd_ptr <= '0;
        end else if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

endmodule

// ==== hdl/uart_pkg.sv ====
// shared widths, FIFO sizing, divider reset value and register map of the UART
package uart_pkg;

    // ------------------------------
    // AXI4-Lite bus
    // ------------------------------
    localparam int DATA_BITS = 32;
    localparam int STRB_BITS = 4;
    localparam int ADDR_BITS = 4;
    localparam int WORD_BITS = ADDR_BITS - 2;

    // ------------------------------
    // baud and FIFO sizing
    // ------------------------------
    localparam int DIVIDER_BITS = 16;
    // one bit lasts divider+1 clocks
    localparam logic [DIVIDER_BITS-1:0] INIT_DIVIDER = 16'd53;
    localparam int FIFO_PTR_BITS = 4;
    localparam int FIFO_DEPTH = 1 << FIFO_PTR_BITS;

    // word indices
    localparam logic [WORD_BITS-1:0] REG_DATA = 2'd0;
    localparam logic [WORD_BITS-1:0] REG_STATUS = 2'd1;
    localparam logic [WORD_BITS-1:0] REG_DIVIDER = 2'd2;

    // status word layout
    localparam int STAT_RX_VALID = 0;
    localparam int STAT_TX_READY = 1;
    localparam int STAT_TX_FREE_LSB = 8;
    localparam int STAT_RX_COUNT_LSB = 16;

endpackage

// ==== hdl/uart_regs.sv ====
// AXI4-Lite register slave with byte push and pop, divider and interrupts
`timescale 1ns/10ps

module uart_regs (
    input  logic                            s_axi4l,
    input  logic                            rst_n,
    input  logic [uart_pkg::ADDR_BITS-1:0]  awaddr,
    input  logic                            awvalid,
    output logic                            awready,
    input  logic [uart_pkg::DATA_BITS-1:0]  wdata,
    input  logic [uart_pkg::STRB_BITS-1:0]  wstrb,
    input  logic                            wvalid,
    output logic                            wready,
    output logic [1:0]                      bresp,
    output logic                            bvalid,
    input  logic                            bready,
    input  logic [uart_pkg::ADDR_BITS-1:0]  araddr,
    input  logic                            arvalid,
    output logic                            arready,
    output logic [uart_pkg::DATA_BITS-1:0]  rdata,
    output logic [1:0]                      rresp,
    output logic                            rvalid,
    input  logic                            rready,
    uart_ctrl_if.regs                       ctrl,
    output logic                            irq_tx,
    output logic                            irq_rx
);
    import uart_pkg::*;

    logic [WORD_BITS-1:0] wr_index;
    logic [WORD_BITS-1:0] rd_index;
    logic wr_fire;
    logic rd_fire;
    logic [DATA_BITS-1:0] status_word;
    logic [DATA_BITS-1:0] rd_word;

    // byte-strobed merge into the divider
    function automatic logic [DIVIDER_BITS-1:0] merge_divider(
        input logic [DIVIDER_BITS-1:0] cur,
        input logic [DATA_BITS-1:0]    data,
        input logic [STRB_BITS-1:0]    strb
    );
        logic [DIVIDER_BITS-1:0] result;
        result = cur;
        for (int i = 0; i < DIVIDER_BITS; i++) begin
            if (strb[i/8]) begin
                result[i] = data[i];
            end
        end
        return result;
    endfunction

    assign wr_index = awaddr[ADDR_BITS-1:2];
    assign rd_index = araddr[ADDR_BITS-1:2];

    // ------------------------------
    // write channel
    // ------------------------------
    // address and data are taken together
    assign awready = awvalid && wvalid && (!bvalid || bready);
    assign wready  = awready;
    assign wr_fire = awvalid && awready;
    assign bresp   = 2'b00;

    assign ctrl.tx_data  = wdata[7:0];
    assign ctrl.tx_valid = wr_fire && (wr_index == REG_DATA) && wstrb[0];

    always_ff @(posedge s_axi4l) begin
        if (!rst_n) begin
            bvalid <= 1'b0;
        end else if (wr_fire) begin
            bvalid <= 1'b1;
        end else if (bready) begin
            bvalid <= 1'b0;
        end
    end

    always_ff @(posedge s_axi4l) begin
        if (!rst_n) begin
            ctrl.divider <= INIT_DIVIDER;
        end else if (wr_fire && (wr_index == REG_DIVIDER)) begin
            ctrl.divider <= merge_divider(ctrl.divider, wdata, wstrb);
        end
    end

    // ------------------------------
    // read channel
    // ------------------------------
    assign arready = !rvalid || rready;
    assign rd_fire = arvalid && arready;
    assign rresp   = 2'b00;

    // pop strobe, ignored by the FIFO when empty
    assign ctrl.rx_ready = rd_fire && (rd_index == REG_DATA);

    always_comb begin
        status_word = '0;
        status_word[STAT_RX_VALID] = ctrl.rx_valid;
        status_word[STAT_TX_READY] = ctrl.tx_ready;
        status_word[STAT_TX_FREE_LSB +: FIFO_PTR_BITS+1] = ctrl.tx_free_count;
        status_word[STAT_RX_COUNT_LSB +: FIFO_PTR_BITS+1] = ctrl.rx_data_count;
    end

    always_comb begin
        case (rd_index)
            REG_DATA:    rd_word = ctrl.rx_valid ? DATA_BITS'(ctrl.rx_data) : '0;
            REG_STATUS:  rd_word = status_word;
            REG_DIVIDER: rd_word = DATA_BITS'(ctrl.divider);
            default:     rd_word = '0;
        endcase
    end

    always_ff @(posedge s_axi4l) begin
        if (rd_fire) begin
            rdata <= rd_word;
        end
    end

    always_ff @(posedge s_axi4l) begin
        if (!rst_n) begin
            rvalid <= 1'b0;
        end else if (rd_fire) begin
            rvalid <= 1'b1;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    // tx empty and serializer idle
    assign irq_tx = (ctrl.tx_free_count == (FIFO_PTR_BITS+1)'(FIFO_DEPTH));
    assign irq_rx = ctrl.rx_valid;

endmodule

// ==== hdl/uart_rx.sv ====
// receive path with line synchronizer, mid-bit sampler and byte FIFO
`timescale 1ns/10ps

module uart_rx (
    input  logic    s_axi4l,
    input  logic    rst_n,
    uart_ctrl_if.rx ctrl,
    input  logic    uart_rx
);
    import uart_pkg::*;

    logic rx_meta;
    logic rx_sync;
    logic active;
    logic sample;
    logic push;
    logic fifo_in_ready;
    logic [DIVIDER_BITS-1:0] baud_cnt;
    logic [3:0] bit_idx;
    logic [7:0] shift_reg;

    // ------------------------------
    // line synchronizer
    // ------------------------------
    always_ff @(posedge s_axi4l) begin
        if (!rst_n) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= uart_rx;
            rx_sync <= rx_meta;
        end
    end

    // ------------------------------
    // bit sampler
    // ------------------------------
    // bit_idx 0 is the start bit, 1..8 data, 9 the stop bit
    assign sample = active && (baud_cnt == '0);

    always_ff @(posedge s_axi4l) begin
        if (!rst_n) begin
            active   <= 1'b0;
            baud_cnt <= '0;
            bit_idx  <= '0;
            push     <= 1'b0;
        end else begin
            push <= 1'b0;
            if (!active) begin
                // half a bit to reach the middle of the start bit
                active   <= !rx_sync;
                baud_cnt <= ctrl.divider >> 1;
                bit_idx  <= '0;
            end else if (!sample) begin
                baud_cnt <= baud_cnt - 1'b1;
            end else begin
                baud_cnt <= ctrl.divider;
                bit_idx  <= bit_idx + 1'b1;
                if (bit_idx == 4'd0 && rx_sync) begin
                    active <= 1'b0;
                end else if (bit_idx == 4'd9) begin
                    active <= 1'b0;
                    // bad stop bit or full FIFO drops the byte
                    push   <= rx_sync && fifo_in_ready;
                end
            end
        end
    end

    always_ff @(posedge s_axi4l) begin
        if (sample && bit_idx >= 4'd1 && bit_idx <= 4'd8) begin
            shift_reg <= {rx_sync, shift_reg[7:1]};
        end
    end

    uart_fifo u_fifo (
        .s_axi4l   (s_axi4l),
        .rst_n     (rst_n),
        .in_data   (shift_reg),
        .in_valid  (push),
        .in_ready  (fifo_in_ready),
        .out_data  (ctrl.rx_data),
        .out_valid (ctrl.rx_valid),
        .out_ready (ctrl.rx_ready),
        .count     (ctrl.rx_data_count)
    );

endmodule

// ==== hdl/uart_top.sv ====
// UART peripheral top with AXI4-Lite slave, serial pins and interrupts
`timescale 1ns/10ps

module uart_top (
    input  logic                            s_axi4l,
    input  logic                            rst_n,
    input  logic [uart_pkg::ADDR_BITS-1:0]  awaddr,
    input  logic                            awvalid,
    output logic                            awready,
    input  logic [uart_pkg::DATA_BITS-1:0]  wdata,
    input  logic [uart_pkg::STRB_BITS-1:0]  wstrb,
    input  logic                            wvalid,
    output logic                            wready,
    output logic [1:0]                      bresp,
    output logic                            bvalid,
    input  logic                            bready,
    input  logic [uart_pkg::ADDR_BITS-1:0]  araddr,
    input  logic                            arvalid,
    output logic                            arready,
    output logic [uart_pkg::DATA_BITS-1:0]  rdata,
    output logic [1:0]                      rresp,
    output logic                            rvalid,
    input  logic                            rready,
    output logic                            uart_tx,
    input  logic                            uart_rx,
    output logic                            irq_tx,
    output logic                            irq_rx
);

    uart_ctrl_if ctrl ();

    // ------------------------------
    // register slave
    // ------------------------------
    uart_regs u_regs (
        .s_axi4l (s_axi4l),
        .rst_n   (rst_n),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready),
        .ctrl    (ctrl.regs),
        .irq_tx  (irq_tx),
        .irq_rx  (irq_rx)
    );

    // serial paths
    uart_tx u_tx (
        .s_axi4l (s_axi4l),
        .rst_n   (rst_n),
        .ctrl    (ctrl.tx),
        .uart_tx (uart_tx)
    );

    uart_rx u_rx (
        .s_axi4l (s_axi4l),
        .rst_n   (rst_n),
        .ctrl    (ctrl.rx),
        .uart_rx (uart_rx)
    );

endmodule

// ==== hdl/uart_tx.sv ====
// transmit path with a byte FIFO and an 8N1 serializer
`timescale 1ns/10ps

module uart_tx (
    input  logic    s_axi4l,
    input  logic    rst_n,
    uart_ctrl_if.tx ctrl,
    output logic    uart_tx
);
    import uart_pkg::*;

    logic [7:0] fifo_data;
    logic fifo_valid;
    logic fifo_ready;
    logic fifo_in_ready;
    logic push_ok;
    logic [FIFO_PTR_BITS:0] fifo_count;
    logic [FIFO_PTR_BITS:0] free_space;
    logic busy;
    logic last_tick;
    logic load;
    logic [DIVIDER_BITS-1:0] baud_cnt;
    logic [3:0] bit_cnt;
    logic [9:0] shift_reg;

    // one slot held back while a frame is on the line
    assign free_space = (FIFO_PTR_BITS+1)'(FIFO_DEPTH) - fifo_count;
    assign ctrl.tx_free_count = (busy && free_space != '0) ? free_space - 1'b1 : free_space;
    assign ctrl.tx_ready = fifo_in_ready && (ctrl.tx_free_count != '0);
    assign push_ok = ctrl.tx_valid && ctrl.tx_ready;

    uart_fifo u_fifo (
        .s_axi4l   (s_axi4l),
        .rst_n     (rst_n),
        .in_data   (ctrl.tx_data),
        .in_valid  (push_ok),
        .in_ready  (fifo_in_ready),
        .out_data  (fifo_data),
        .out_valid (fifo_valid),
        .out_ready (fifo_ready),
        .count     (fifo_count)
    );

    // ------------------------------
    // serializer
    // ------------------------------
    // next frame loads on the last clock of the stop bit
    assign last_tick  = busy && (baud_cnt == '0) && (bit_cnt == 4'd9);
    assign fifo_ready = !busy || last_tick;
    assign load       = fifo_valid && fifo_ready;

    always_ff @(posedge s_axi4l) begin
        if (!rst_n) begin
            busy      <= 1'b0;
            shift_reg <= '1;
            bit_cnt   <= '0;
            baud_cnt  <= '0;
        end else if (load) begin
            busy      <= 1'b1;
            shift_reg <= {1'b1, fifo_data, 1'b0};
            bit_cnt   <= '0;
            baud_cnt  <= ctrl.divider;
        end else if (busy) begin
            if (baud_cnt != '0) begin
                baud_cnt <= baud_cnt - 1'b1;
            end else if (bit_cnt == 4'd9) begin
                busy <= 1'b0;
            end else begin
                // shift in ones so the line idles high
                shift_reg <= {1'b1, shift_reg[9:1]};
                bit_cnt   <= bit_cnt + 1'b1;
                baud_cnt  <= ctrl.divider;
            end
        end
    end

    assign uart_tx = shift_reg[0];

endmodule

// ==== project.f ====
hdl/uart_pkg.sv
hdl/uart_ctrl_if.sv
hdl/uart_fifo.sv
hdl/uart_regs.sv
hdl/uart_tx.sv
hdl/uart_rx.sv
hdl/uart_top.sv
test/uart_tb_assertions.sv
test/uart_tb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module uart_tb -f project.f -o uart_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/uart_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "All tests passed!"; then
    exit 0
fi
exit 1

// ==== test/uart_tb.sv ====
// testbench for the UART peripheral with serial loopback and a register model
`timescale 1ns/10ps

module uart_tb;
    import uart_pkg::*;

    localparam int FAST_DIVIDER = 7;
    localparam int NUM_BURSTS = 6;
    localparam int STALL_BYTES = 8;
    localparam int TOTAL_BYTES = NUM_BURSTS * FIFO_DEPTH + FIFO_DEPTH + 1 + STALL_BYTES;
    localparam int CYCLE_LIMIT = TOTAL_BYTES * 10 * (FAST_DIVIDER + 1) + 20000;

    logic s_axi4l;
    logic rst_n;
    logic [ADDR_BITS-1:0] awaddr;
    logic [ADDR_BITS-1:0] araddr;
    logic [DATA_BITS-1:0] wdata;
    logic [DATA_BITS-1:0] rdata;
    logic [STRB_BITS-1:0] wstrb;
    logic [1:0] bresp;
    logic [1:0] rresp;
    logic awvalid;
    logic awready;
    logic wvalid;
    logic wready;
    logic bvalid;
    logic bready;
    logic arvalid;
    logic arready;
    logic rvalid;
    logic rready;
    logic uart_tx;
    logic uart_rx;
    logic irq_tx;
    logic irq_rx;

    int seed = 82;
    int cycle_count = 0;
    int writes_done = 0;
    int reads_done = 0;
    int bresps_seen = 0;
    int rresps_seen = 0;
    logic stall_en = 1'b0;
    logic [DIVIDER_BITS-1:0] div_model;
    logic [7:0] expected_q[$];

    uart_top dut (.*);

    // serial loopback
    assign uart_rx = uart_tx;

    initial begin
        s_axi4l = 1'b0;
        forever #10 s_axi4l = ~s_axi4l;
    end

    initial begin
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge s_axi4l);
            cycle_count++;
        end
        $display("timeout: no result after %0d clock cycles", CYCLE_LIMIT);
        $display("Test failures found");
        $fatal(1, "simulation timeout");
    end

    // ------------------------------
    // back-pressure and response count
    // ------------------------------
    initial begin
        bready = 1'b1;
        rready = 1'b1;
        forever begin
            @(negedge s_axi4l);
            bready = !stall_en || (($random(seed) & 1) != 0);
            rready = !stall_en || (($random(seed) & 1) != 0);
        end
    end

    // a handshake seen here completes at the next rising edge
    initial begin
        forever begin
            @(negedge s_axi4l);
            #1;
            if (bvalid && bready) begin
                bresps_seen++;
                check_bit("bresp", bresp, 2'b00);
            end
            if (rvalid && rready) begin
                rresps_seen++;
                check_bit("rresp", rresp, 2'b00);
            end
        end
    end

    task automatic check_word(input string name, input logic [DATA_BITS-1:0] actual,
                              input logic [DATA_BITS-1:0] expected);
        if (actual !== expected) begin
            $display("MISMATCH %s: got 0x%h, expected 0x%h", name, actual, expected);
            $display("Test failures found");
            $fatal(1, "%s mismatch", name);
        end
    endtask

    task automatic check_bit(input string name, input logic [1:0] actual,
                             input logic [1:0] expected);
        if (actual !== expected) begin
            $display("MISMATCH %s: got 0x%h, expected 0x%h", name, actual, expected);
            $display("Test failures found");
            $fatal(1, "%s mismatch", name);
        end
    endtask

    function automatic logic [DATA_BITS-1:0] expected_status(input int tx_free,
                                                             input int rx_count);
        logic [DATA_BITS-1:0] w;
        w = '0;
        w[STAT_RX_VALID] = (rx_count != 0);
        w[STAT_TX_READY] = (tx_free != 0);
        w[STAT_TX_FREE_LSB +: FIFO_PTR_BITS+1] = tx_free[FIFO_PTR_BITS:0];
        w[STAT_RX_COUNT_LSB +: FIFO_PTR_BITS+1] = rx_count[FIFO_PTR_BITS:0];
        return w;
    endfunction

    task automatic bus_write(input logic [ADDR_BITS-1:0] addr, input logic [DATA_BITS-1:0] data,
                             input logic [STRB_BITS-1:0] strb);
        @(negedge s_axi4l);
        awaddr = addr;
        wdata = data;
        wstrb = strb;
        awvalid = 1'b1;
        wvalid = 1'b1;
        #1;
        while (!awready) begin
            @(negedge s_axi4l);
            #1;
        end
        // address and data go in together
        check_bit("wready", 2'(wready), 2'b01);
        @(negedge s_axi4l);
        awvalid = 1'b0;
        wvalid = 1'b0;
        writes_done++;
    endtask

    task automatic bus_read(input logic [ADDR_BITS-1:0] addr, output logic [DATA_BITS-1:0] data);
        @(negedge s_axi4l);
        araddr = addr;
        arvalid = 1'b1;
        #1;
        while (!arready) begin
            @(negedge s_axi4l);
            #1;
        end
        @(negedge s_axi4l);
        arvalid = 1'b0;
        #1;
        while (!(rvalid && rready)) begin
            @(negedge s_axi4l);
            #1;
        end
        data = rdata;
        reads_done++;
    endtask

    task automatic divider_rounds(input int rounds);
        logic [DATA_BITS-1:0] data;
        logic [DATA_BITS-1:0] word;
        logic [STRB_BITS-1:0] strb;
        for (int i = 0; i < rounds; i++) begin
            data = $random(seed);
            strb = 4'($random(seed));
            if (i == rounds - 1) begin
                data = FAST_DIVIDER;
                strb = 4'hf;
            end
            bus_write({REG_DIVIDER, 2'b00}, data, strb);
            if (strb[0]) div_model[7:0] = data[7:0];
            if (strb[1]) div_model[15:8] = data[15:8];
            bus_read({REG_DIVIDER, 2'b00}, word);
            check_word("divider", word, DATA_BITS'(div_model));
        end
    endtask

    task automatic send_bytes(input int n);
        logic [7:0] b;
        for (int i = 0; i < n; i++) begin
            b = 8'($random(seed));
            bus_write({REG_DATA, 2'b00}, {24'($random(seed)), b}, 4'b0001 | 4'($random(seed)));
            expected_q.push_back(b);
            if (i == 0) check_bit("irq_tx", 2'(irq_tx), 2'b00);
        end
    endtask

    task automatic wait_rx_count(input int n);
        logic [DATA_BITS-1:0] word;
        int count;
        count = 0;
        do begin
            bus_read({REG_STATUS, 2'b00}, word);
            count = int'(word[STAT_RX_COUNT_LSB +: FIFO_PTR_BITS+1]);
            check_bit("rx_valid", 2'(word[STAT_RX_VALID]), 2'(count != 0));
        end while (count < n);
        check_bit("irq_rx", 2'(irq_rx), 2'b01);
    endtask

    task automatic drain_bytes(input int n);
        logic [DATA_BITS-1:0] word;
        for (int i = 0; i < n; i++) begin
            bus_read({REG_DATA, 2'b00}, word);
            check_word("rdata", word, DATA_BITS'(expected_q.pop_front()));
        end
        // empty FIFO reads back zero
        bus_read({REG_DATA, 2'b00}, word);
        check_word("rdata", word, '0);
        check_bit("irq_rx", 2'(irq_rx), 2'b00);
    endtask

    task automatic wait_tx_idle();
        do begin
            @(negedge s_axi4l);
            #1;
        end while (!irq_tx);
    endtask

    // ------------------------------
    // test sequence
    // ------------------------------
    initial begin
        logic [DATA_BITS-1:0] word;
        int n;
        rst_n = 1'b0;
        awaddr = '0;
        awvalid = 1'b0;
        wdata = '0;
        wstrb = '0;
        wvalid = 1'b0;
        araddr = '0;
        arvalid = 1'b0;
        repeat (5) @(negedge s_axi4l);
        rst_n = 1'b1;

        bus_read({REG_DIVIDER, 2'b00}, word);
        check_word("divider", word, 32'd53);
        bus_read({REG_STATUS, 2'b00}, word);
        check_word("status", word, expected_status(FIFO_DEPTH, 0));
        check_bit("irq_tx", 2'(irq_tx), 2'b01);
        check_bit("irq_rx", 2'(irq_rx), 2'b00);

        div_model = 16'd53;
        divider_rounds(10);

        repeat (NUM_BURSTS) begin
            n = 1 + ($random(seed) & 15);
            send_bytes(n);
            wait_rx_count(n);
            drain_bytes(n);
            wait_tx_idle();
            bus_read({REG_STATUS, 2'b00}, word);
            check_word("status", word, expected_status(FIFO_DEPTH, 0));
        end

        // full TX FIFO, then one byte that must be dropped
        send_bytes(FIFO_DEPTH);
        bus_read({REG_STATUS, 2'b00}, word);
        check_word("status", word, expected_status(0, 0));
        bus_write({REG_DATA, 2'b00}, 32'h0000_00a5, 4'b0001);
        // early pop leaves RX room for the dropped byte
        wait_rx_count(1);
        bus_read({REG_DATA, 2'b00}, word);
        check_word("rdata", word, DATA_BITS'(expected_q.pop_front()));
        wait_tx_idle();
        repeat (20 * (FAST_DIVIDER + 1)) @(negedge s_axi4l);
        bus_read({REG_STATUS, 2'b00}, word);
        check_word("status", word, expected_status(FIFO_DEPTH, FIFO_DEPTH - 1));
        drain_bytes(FIFO_DEPTH - 1);

        stall_en = 1'b1;
        divider_rounds(12);
        send_bytes(STALL_BYTES);
        wait_rx_count(STALL_BYTES);
        drain_bytes(STALL_BYTES);
        wait_tx_idle();
        stall_en = 1'b0;
        repeat (3) @(negedge s_axi4l);
        #1;
        check_word("bvalid_count", bresps_seen, writes_done);
        check_word("rvalid_count", rresps_seen, reads_done);

        $display("All tests passed!");
        $finish;
    end

endmodule

// ==== test/uart_tb_assertions.sv ====
// AXI4-Lite response checks bound into the register slave
`timescale 1ns/10ps

module uart_tb_assertions (
    input logic                           s_axi4l,
    input logic                           rst_n,
    input logic                           awvalid,
    input logic                           awready,
    input logic                           bvalid,
    input logic                           bready,
    input logic                           arvalid,
    input logic                           arready,
    input logic [uart_pkg::DATA_BITS-1:0] rdata,
    input logic                           rvalid,
    input logic                           rready
);

    // responses hold until taken
    bvalid_hold: assert property (@(posedge s_axi4l) disable iff (!rst_n)
        bvalid && !bready |=> bvalid)
        else $error("bvalid dropped before bready");

    rvalid_hold: assert property (@(posedge s_axi4l) disable iff (!rst_n)
        rvalid && !rready |=> rvalid)
        else $error("rvalid dropped before rready");

    // every accepted request gets its response on the next clock
    bvalid_after_write: assert property (@(posedge s_axi4l) disable iff (!rst_n)
        awvalid && awready |=> bvalid)
        else $error("no write response after an accepted write");

    rvalid_after_read: assert property (@(posedge s_axi4l) disable iff (!rst_n)
        arvalid && arready |=> rvalid)
        else $error("no read response after an accepted read");

    rdata_hold: assert property (@(posedge s_axi4l) disable iff (!rst_n)
        rvalid && !rready |=> $stable(rdata))
        else $error("read data changed while waiting for rready");

endmodule

bind uart_regs uart_tb_assertions u_assertions (
    .s_axi4l (s_axi4l),
    .rst_n   (rst_n),
    .awvalid (awvalid),
    .awready (awready),
    .bvalid  (bvalid),
    .bready  (bready),
    .arvalid (arvalid),
    .arready (arready),
    .rdata   (rdata),
    .rvalid  (rvalid),
    .rready  (rready)
);
